// ==== hw/rv32_mem_pkg.sv ====
// shared RV32 memory stage types; XLEN fixed at 32, union views assume 8-bit bytes and 16-bit halves.
package rv32_mem_pkg;

    parameter int XLEN        = 32;
    parameter int BYTE_LANES  = XLEN / 8;
    parameter int HALF_LANES  = XLEN / 16;
    parameter int OFFSET_BITS = $clog2(BYTE_LANES); // byte offset within a word.

    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LH  = 4'd2,
        MEM_LW  = 4'd3,
        MEM_LBU = 4'd4,
        MEM_LHU = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_op_t;

    // one data word, lane 0 least significant.
    typedef union packed {
        logic [BYTE_LANES-1:0][7:0]  b;
        logic [HALF_LANES-1:0][15:0] h;
    } mem_word_u;

    function automatic logic is_load(mem_op_t op);
        return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
    endfunction

    function automatic logic is_store(mem_op_t op);
        return op inside {MEM_SB, MEM_SH, MEM_SW};
    endfunction

    // halves need bit 0 clear, words need both offset bits clear.
    function automatic logic is_misaligned(mem_op_t op, logic [OFFSET_BITS-1:0] offset);
        logic result;
        case (op)
            MEM_LH, MEM_LHU, MEM_SH: result = offset[0];
            MEM_LW, MEM_SW:          result = |offset;
            default:                 result = 1'b0;
        endcase
        return result;
    endfunction

endpackage

// ==== hw/rv32_load_store_unit.sv ====
// one access in flight at a time; misaligned halves and words fault and never reach memory.
module rv32_load_store_unit
    import rv32_mem_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    // exec side.
    input  logic                  req,
    input  mem_op_t               op,
    input  logic [XLEN-1:0]       addr,
    input  logic [XLEN-1:0]       wdata,
    output logic                  ack,
    output logic [XLEN-1:0]       rdata,
    output logic                  fault,
    // data memory side.
    output logic                  mem_req,
    output logic                  mem_we,
    output logic [XLEN-1:0]       mem_addr,
    output logic [BYTE_LANES-1:0] mem_be,
    output mem_word_u             mem_wdata,
    input  logic                  mem_ack,
    input  mem_word_u             mem_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_DONE,
        ST_RELEASE
    } state_t;

    state_t                 state;
    mem_op_t                op_q;
    logic [XLEN-1:0]        addr_q;
    logic [XLEN-1:0]        wdata_q;

    logic [OFFSET_BITS-1:0] offset;
    logic                   misaligned;
    logic                   access_ok;
    logic [7:0]             load_byte;
    logic [15:0]            load_half;
    logic [XLEN-1:0]        load_data;
    mem_word_u              store_word;

    assign offset     = addr_q[OFFSET_BITS-1:0];
    assign misaligned = is_misaligned(op_q, offset);
    assign access_ok  = (is_load(op_q) || is_store(op_q)) && !misaligned;

    // held through done so the memory link parks while exec keeps req up.
    assign mem_req   = access_ok && (state == ST_ACCESS || state == ST_DONE);
    assign mem_we    = mem_req && is_store(op_q);
    assign mem_addr  = {addr_q[XLEN-1:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign mem_wdata = store_word;

    // store data is replicated and the enables pick the lane.
    always_comb begin
        store_word = wdata_q;
        mem_be     = '0;
        case (op_q)
            MEM_SB: begin
                store_word.b = {BYTE_LANES{wdata_q[7:0]}};
                mem_be       = BYTE_LANES'(1) << offset;
            end
            MEM_SH: begin
                store_word.h = {HALF_LANES{wdata_q[15:0]}};
                mem_be       = offset[1] ? 4'b1100 : 4'b0011;
            end
            MEM_SW: begin
                mem_be = '1;
            end
            default: ;
        endcase
    end

    assign load_byte = mem_rdata.b[offset];
    assign load_half = mem_rdata.h[offset[1]];

    always_comb begin
        case (op_q)
            MEM_LB:  load_data = {{(XLEN-8){load_byte[7]}}, load_byte};
            MEM_LBU: load_data = {{(XLEN-8){1'b0}}, load_byte};
            MEM_LH:  load_data = {{(XLEN-16){load_half[15]}}, load_half};
            MEM_LHU: load_data = {{(XLEN-16){1'b0}}, load_half};
            MEM_LW:  load_data = mem_rdata;
            default: load_data = '0; // stores and nop.
        endcase
    end

    // request capture.
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            op_q    <= op;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
            fault <= 1'b0;
            rdata <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        state <= ST_ACCESS;
                    end
                end
                ST_ACCESS: begin
                    if (!access_ok) begin // nop or fault skips the memory.
                        ack   <= 1'b1;
                        fault <= misaligned;
                        rdata <= '0;
                        state <= ST_DONE;
                    end else if (mem_ack) begin
                        ack   <= 1'b1;
                        fault <= 1'b0;
                        rdata <= load_data;
                        state <= ST_DONE;
                    end
                end
                ST_DONE: begin
                    if (!req) begin
                        state <= ST_RELEASE; // drops mem_req.
                    end
                end
                ST_RELEASE: begin
                    if (!mem_ack) begin
                        ack   <= 1'b0;
                        fault <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

// ==== hw/rv32_data_memory.sv ====
// DEPTH_WORDS must be a power of two of at least 2; high address bits wrap, ACK_DELAY at least 1.
module rv32_data_memory
    import rv32_mem_pkg::*;
#(
    parameter int DEPTH_WORDS = 16,
    parameter int ACK_DELAY   = 1
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mem_req,
    input  logic                  mem_we,
    input  logic [XLEN-1:0]       mem_addr,
    input  logic [BYTE_LANES-1:0] mem_be,
    input  mem_word_u             mem_wdata,
    output logic                  mem_ack,
    output mem_word_u             mem_rdata
);

    localparam int IDX_W = $clog2(DEPTH_WORDS);
    localparam int CNT_W = $clog2(ACK_DELAY + 1);

    mem_word_u        mem_array [DEPTH_WORDS];
    logic [CNT_W-1:0] delay_cnt;
    logic [IDX_W-1:0] word_idx;
    logic             fire;

    assign word_idx = mem_addr[OFFSET_BITS +: IDX_W];

    // cycle in which ack rises and the access takes place.
    assign fire = mem_req && !mem_ack && (delay_cnt == CNT_W'(ACK_DELAY));

    initial begin
        for (int i = 0; i < DEPTH_WORDS; i++) begin
            mem_array[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ack   <= 1'b0;
            delay_cnt <= '0;
        end else if (mem_ack) begin
            if (!mem_req) begin
                mem_ack <= 1'b0;
            end
        end else if (fire) begin
            mem_ack   <= 1'b1;
            delay_cnt <= '0;
        end else if (mem_req) begin
            delay_cnt <= delay_cnt + 1'b1;
        end else begin
            delay_cnt <= '0;
        end
    end

    // read returns the old word, write lands in the same cycle.
    always_ff @(posedge clk) begin
        if (fire) begin
            mem_rdata <= mem_array[word_idx];
            if (mem_we) begin
                for (int lane = 0; lane < BYTE_LANES; lane++) begin
                    if (mem_be[lane]) begin
                        mem_array[word_idx].b[lane] <= mem_wdata.b[lane];
                    end
                end
            end
        end
    end

endmodule

// ==== hw/rv32_mem_stage.sv ====
// memory stage top; latency is ACK_DELAY plus 2 cycles for memory ops and 1 cycle for nop or fault.
module rv32_mem_stage
    import rv32_mem_pkg::*;
#(
    parameter int DEPTH_WORDS = 256,
    parameter int ACK_DELAY   = 2
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            req,
    input  mem_op_t         op,
    input  logic [XLEN-1:0] addr,
    input  logic [XLEN-1:0] wdata,
    output logic            ack,
    output logic [XLEN-1:0] rdata,
    output logic            fault
);

    logic                  mem_req;
    logic                  mem_we;
    logic [XLEN-1:0]       mem_addr;
    logic [BYTE_LANES-1:0] mem_be;
    mem_word_u             mem_wdata;
    logic                  mem_ack;
    mem_word_u             mem_rdata;

    rv32_load_store_unit i_rv32_load_store_unit (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .op        (op),
        .addr      (addr),
        .wdata     (wdata),
        .ack       (ack),
        .rdata     (rdata),
        .fault     (fault),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_be    (mem_be),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

    rv32_data_memory #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .ACK_DELAY   (ACK_DELAY)
    ) i_rv32_data_memory (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_be    (mem_be),
        .mem_wdata (mem_wdata),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata)
    );

endmodule

// ==== include/rv32_mem_ref.svh ====
// include inside a module that imports rv32_mem_pkg; REF_DEPTH_WORDS must equal the DUT DEPTH_WORDS.
`ifndef RV32_MEM_REF_SVH
`define RV32_MEM_REF_SVH

localparam int REF_DEPTH_WORDS = 256;

logic [XLEN-1:0] ref_mem [REF_DEPTH_WORDS] = '{default: '0}; // shadow of the data memory.

function automatic int unsigned ref_index(logic [XLEN-1:0] addr);
    return (addr >> 2) % REF_DEPTH_WORDS; // wraps like the DUT.
endfunction

function automatic logic ref_fault(mem_op_t op, logic [XLEN-1:0] addr);
    if (op == MEM_LH || op == MEM_LHU || op == MEM_SH) begin
        return addr[0];
    end
    if (op == MEM_LW || op == MEM_SW) begin
        return addr[1:0] != 2'b00;
    end
    return 1'b0;
endfunction

// expected rdata, zero for stores, nop and faults.
function automatic logic [XLEN-1:0] ref_load(mem_op_t op, logic [XLEN-1:0] addr);
    logic [XLEN-1:0] word;
    logic [XLEN-1:0] shifted;
    word    = ref_mem[ref_index(addr)];
    shifted = word >> (8 * addr[1:0]);
    if (ref_fault(op, addr)) begin
        return '0;
    end
    case (op)
        MEM_LB:  return {{24{shifted[7]}}, shifted[7:0]};
        MEM_LBU: return {24'h0, shifted[7:0]};
        MEM_LH:  return {{16{shifted[15]}}, shifted[15:0]};
        MEM_LHU: return {16'h0, shifted[15:0]};
        MEM_LW:  return word;
        default: return '0;
    endcase
endfunction

function automatic void ref_store(mem_op_t op, logic [XLEN-1:0] addr, logic [XLEN-1:0] wdata);
    logic [XLEN-1:0] mask;
    int unsigned     idx;
    idx = ref_index(addr);
    case (op)
        MEM_SB:  mask = 32'h0000_00ff << (8 * addr[1:0]);
        MEM_SH:  mask = 32'h0000_ffff << (8 * addr[1:0]);
        MEM_SW:  mask = 32'hffff_ffff;
        default: mask = '0;
    endcase
    if (!ref_fault(op, addr)) begin
        ref_mem[idx] = (ref_mem[idx] & ~mask) | ((wdata << (8 * addr[1:0])) & mask);
    end
endfunction

`endif

// ==== testbench/tb_rv32_mem_stage.sv ====
// drives the memory stage through directed and LFSR-random ops; stops at the first mismatch.
module tb_rv32_mem_stage
    import rv32_mem_pkg::*;
;

    `include "rv32_mem_ref.svh"

    localparam int DEPTH_WORDS = REF_DEPTH_WORDS;
    localparam int ACK_DELAY   = 2;
    localparam int RESET_CYCLES = 8;
    localparam int CYCLE_LIMIT = (400 * (ACK_DELAY + 8) + RESET_CYCLES) * 2;

    logic            clk;
    logic            rst_n;
    logic            req;
    mem_op_t         op;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    logic            ack;
    logic [XLEN-1:0] rdata;
    logic            fault;

    logic [15:0]     lfsr_q = 16'd50;
    int              cycle_cnt = 0;

    rv32_mem_stage #(
        .DEPTH_WORDS (DEPTH_WORDS),
        .ACK_DELAY   (ACK_DELAY)
    ) i_rv32_mem_stage (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .op    (op),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .fault (fault)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("** Error at time %0t: %s", $time, msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish");
            $display("TB FAILED");
            $fatal(1, "cycle limit reached");
        end
    end

    // handshake rules on the exec link.
    assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> $past(req))
        else report_error("ack rose while req was low");
    assert property (@(posedge clk) disable iff (!rst_n)
        (ack && $past(ack)) |-> ($stable(rdata) && $stable(fault)))
        else report_error("rdata or fault changed while ack was high");
    assert property (@(posedge clk) disable iff (!rst_n) $fell(ack) |-> !$past(req))
        else report_error("ack fell before req had fallen");

    // 16-bit fibonacci lfsr with taps 16 14 13 11 and one step per bit.
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (RESET_CYCLES + 2) begin
            @(posedge clk);
            #1;
            assert (ack === 1'b0 && fault === 1'b0)
                else report_error("ack or fault high around reset");
            if (cycle_cnt == RESET_CYCLES) begin
                rst_n = 1'b1;
            end
        end
    endtask

    // one four-phase transaction with req held for hold extra cycles after ack.
    task automatic run_op(input mem_op_t op_i, input logic [XLEN-1:0] addr_i,
                          input logic [XLEN-1:0] wdata_i, input int hold);
        logic [XLEN-1:0] exp_rdata;
        logic            exp_fault;
        exp_fault = ref_fault(op_i, addr_i);
        exp_rdata = ref_load(op_i, addr_i);
        op    = op_i;
        addr  = addr_i;
        wdata = wdata_i;
        req   = 1'b1;
        while (!ack) begin
            @(posedge clk);
            #1;
        end
        assert (fault === exp_fault && rdata === exp_rdata)
            else report_error($sformatf("%s addr %h: got rdata %h fault %b, expected %h %b",
                                        op_i.name(), addr_i, rdata, fault,
                                        exp_rdata, exp_fault));
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        req = 1'b0;
        while (ack) begin
            @(posedge clk);
            #1;
        end
        ref_store(op_i, addr_i, wdata_i);
    endtask

    task automatic random_mix(input int count);
        logic [3:0]      op_code;
        logic [XLEN-1:0] word_r;
        logic [XLEN-1:0] off_r;
        logic [XLEN-1:0] addr_r;
        logic [XLEN-1:0] data_r;
        int              hold_r;
        for (int n = 0; n < count; n++) begin
            op_code = 4'(next_bits(4) % 9);
            word_r  = next_bits(6); // first 64 words.
            off_r   = next_bits(2);
            addr_r  = word_r * 4 + off_r;
            if (next_bits(3) == 0) begin
                addr_r = addr_r + DEPTH_WORDS * 4 * (next_bits(4) + 1); // wraps.
            end
            data_r = next_bits(32);
            hold_r = int'(next_bits(2));
            run_op(mem_op_t'(op_code), addr_r, data_r, hold_r);
        end
    endtask

    initial begin
        req   = 1'b0;
        op    = MEM_NOP;
        addr  = '0;
        wdata = '0;
        rst_n = 1'b0;
        apply_reset();

        // every load width against one known word.
        run_op(MEM_SW, 32'h40, 32'h8a7f_c301, 0);
        for (int off = 0; off < 4; off++) begin
            run_op(MEM_LB, 32'h40 + off, '0, 0);
            run_op(MEM_LBU, 32'h40 + off, '0, 1);
        end
        run_op(MEM_LH, 32'h40, '0, 0);
        run_op(MEM_LH, 32'h42, '0, 0);
        run_op(MEM_LHU, 32'h40, '0, 0);
        run_op(MEM_LHU, 32'h42, '0, 3);
        run_op(MEM_LW, 32'h40, '0, 0);

        // partial stores over a pattern.
        run_op(MEM_SW, 32'h50, 32'ha5a5_5a5a, 0);
        run_op(MEM_SB, 32'h51, 32'h1234_5677, 0);
        run_op(MEM_LW, 32'h50, '0, 0);
        run_op(MEM_SH, 32'h52, 32'h0000_beef, 2);
        run_op(MEM_LW, 32'h50, '0, 0);
        run_op(MEM_SB, 32'h50, 32'h0000_0080, 0);
        run_op(MEM_SB, 32'h53, 32'h0000_00c4, 0);
        run_op(MEM_SH, 32'h50, 32'h0000_7e11, 0);
        run_op(MEM_LW, 32'h50, '0, 0);

        // misaligned ops fault and leave memory alone.
        run_op(MEM_LH, 32'h41, '0, 0);
        run_op(MEM_LHU, 32'h43, '0, 0);
        run_op(MEM_SH, 32'h41, 32'hffff_ffff, 0);
        run_op(MEM_LW, 32'h42, '0, 0);
        run_op(MEM_SW, 32'h41, 32'hffff_ffff, 3);
        run_op(MEM_SW, 32'h43, 32'h0bad_0bad, 0);
        run_op(MEM_LW, 32'h40, '0, 0);
        run_op(MEM_NOP, 32'h44, 32'hdead_beef, 0);

        // same word through an address past the end of memory.
        run_op(MEM_SW, 32'h40 + DEPTH_WORDS * 4, 32'h1357_9bdf, 0);
        run_op(MEM_LW, 32'h40, '0, 0);

        random_mix(300);

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== rv32_mem.f ====
+incdir+include
hw/rv32_mem_pkg.sv
hw/rv32_load_store_unit.sv
hw/rv32_data_memory.sv
hw/rv32_mem_stage.sv
testbench/tb_rv32_mem_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compiles the memory stage testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
TOP=tb_rv32_mem_stage

verilator --binary --timing --assert -Wno-fatal -f rv32_mem.f \
    --top-module "$TOP" -Mdir "$BUILD_DIR"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
SIM_STATUS=$?
cat "$LOG"
if [ $SIM_STATUS -ne 0 ]; then
    echo "simulation exited with status $SIM_STATUS"
    exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
